// ==== source/decodePkg.sv ====
package decodePkg;

	// Opcodes that the decoder handles by name.
	localparam logic [4:0] OP_HALT = 5'b00000;
	localparam logic [4:0] OP_NOP  = 5'b00001;
	localparam logic [4:0] OP_J    = 5'b00100;
	localparam logic [4:0] OP_JR   = 5'b00101;
	localparam logic [4:0] OP_JAL  = 5'b00110;
	localparam logic [4:0] OP_JALR = 5'b00111;
	localparam logic [4:0] OP_ST   = 5'b10000;
	localparam logic [4:0] OP_LD   = 5'b10001;
	localparam logic [4:0] OP_SLBI = 5'b10010;
	localparam logic [4:0] OP_STU  = 5'b10011;
	localparam logic [4:0] OP_LBI  = 5'b11000;
	localparam logic [4:0] OP_BTR  = 5'b11001; // Bit reverse, register format.

	localparam logic [2:0] LINK_REG = 3'd7; // Return address register for JAL and JALR.
	localparam int REG_COUNT = 8;

	// Field layout selector.
	typedef logic [1:0] instrFormat;

	localparam instrFormat FMT_J  = 2'd0;
	localparam instrFormat FMT_I1 = 2'd1;
	localparam instrFormat FMT_I2 = 2'd2;
	localparam instrFormat FMT_R  = 2'd3;

	typedef struct packed {
		logic [4:0] opcode;
		logic [10:0] disp; // Signed jump displacement.
	} jLayout;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm;
	} i1Layout;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs; // Source, and destination for LBI and SLBI.
		logic [7:0] imm;
	} i2Layout;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] func; // Selects the operation inside an opcode group.
	} rLayout;

	// One instruction word, seen through each of the four layouts.
	typedef union packed {
		jLayout jFmt;
		i1Layout i1Fmt;
		i2Layout i2Fmt;
		rLayout rFmt;
	} instrWord;

endpackage

// ==== source/formatClassifier.sv ====
module formatClassifier (
	input logic [4:0] opcode,
	output decodePkg::instrFormat format,
	output logic regWrite,
	output logic memRead,
	output logic memWrite
);

	import decodePkg::*;

	logic isLinkJump;
	logic isByteLoad;
	logic isStore;

	assign isLinkJump = (opcode == OP_JAL) || (opcode == OP_JALR);
	assign isByteLoad = (opcode == OP_LBI) || (opcode == OP_SLBI);
	assign isStore = (opcode == OP_ST) || (opcode == OP_STU); // Both write memory.

	always_comb begin
		casez (opcode)
			OP_HALT,
			OP_NOP,
			OP_J,
			OP_JAL: begin
				format = FMT_J;
			end
			OP_JR,
			OP_JALR,
			OP_LBI,
			OP_SLBI,
			5'b011??: begin
				format = FMT_I2; // The 011xx group holds the conditional branches.
			end
			OP_BTR,
			5'b1101?,
			5'b111??: begin
				format = FMT_R; // ALU and set-on-compare groups.
			end
			default: begin
				format = FMT_I1;
			end
		endcase
	end

	always_comb begin
		regWrite = 1'b0;
		if (format == FMT_R) begin
			regWrite = 1'b1;
		end else if (format == FMT_I1) begin
			regWrite = (opcode != OP_ST); // Plain store has no register result.
		end else if (isLinkJump || isByteLoad) begin
			regWrite = 1'b1;
		end
	end

	assign memRead = (opcode == OP_LD);
	assign memWrite = isStore;

	// A clean opcode must never leave the decode outputs floating.
	always_comb begin
		if (!$isunknown(opcode)) begin
			assert final (!$isunknown({format, regWrite, memRead, memWrite}))
				else $error("Format classifier produced an unknown value.");
		end
	end

endmodule

// ==== source/operandDecoder.sv ====
module operandDecoder (
	input decodePkg::instrWord instr,
	input decodePkg::instrFormat format,
	output logic [2:0] readReg1,
	output logic [2:0] readReg2,
	output logic [2:0] writeReg,
	output logic [15:0] immed
);

	import decodePkg::*;

	logic [4:0] opcode;
	logic isJal;
	logic isJalr;
	logic isSt;
	logic isStu;
	logic isByteLoad;
	logic zeroExtI1;
	logic zeroExtI2;
	logic [15:0] jImmed;
	logic [15:0] i1Immed;
	logic [15:0] i2Immed;

	assign opcode = instr.jFmt.opcode; // Opcode sits in the same bits for every layout.

	assign isJal = (opcode == OP_JAL);
	assign isJalr = (opcode == OP_JALR);
	assign isSt = (opcode == OP_ST);
	assign isStu = (opcode == OP_STU);
	assign isByteLoad = (opcode == OP_LBI) || (opcode == OP_SLBI);

	// Instruction bits 14 and 12 both set marks XORI and ANDNI.
	assign zeroExtI1 = opcode[3] & opcode[1];
	// Bit 15 set with bits 12 and 11 different marks SLBI.
	assign zeroExtI2 = opcode[4] & (opcode[1] ^ opcode[0]);

	assign jImmed = {{5{instr.jFmt.disp[10]}}, instr.jFmt.disp};
	assign i1Immed = zeroExtI1 ? {11'd0, instr.i1Fmt.imm}
		: {{11{instr.i1Fmt.imm[4]}}, instr.i1Fmt.imm};
	assign i2Immed = zeroExtI2 ? {8'd0, instr.i2Fmt.imm}
		: {{8{instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};

	always_comb begin
		readReg1 = 3'd0;
		readReg2 = 3'd0;
		writeReg = 3'd0;
		immed = 16'd0;
		case (format)
			FMT_J: begin
				writeReg = isJal ? LINK_REG : 3'd0; // Only JAL leaves a link.
				immed = jImmed;
			end
			FMT_I1: begin
				readReg1 = instr.i1Fmt.rs;
				readReg2 = (isSt || isStu) ? instr.i1Fmt.rd : 3'd0; // Store data comes from rd.
				writeReg = isStu ? instr.i1Fmt.rs : instr.i1Fmt.rd; // STU updates its base.
				immed = i1Immed;
			end
			FMT_I2: begin
				readReg1 = instr.i2Fmt.rs;
				if (isJalr) begin
					writeReg = LINK_REG;
				end else if (isByteLoad) begin
					writeReg = instr.i2Fmt.rs;
				end
				immed = i2Immed;
			end
			FMT_R: begin
				readReg1 = instr.rFmt.rs;
				readReg2 = instr.rFmt.rt;
				writeReg = instr.rFmt.rd;
			end
			default: begin
				immed = 16'd0;
			end
		endcase
	end

endmodule

// ==== source/registerFile.sv ====
module registerFile (
	input logic clk,
	input logic rst,
	input logic [2:0] readReg1,
	input logic [2:0] readReg2,
	input logic writeEnable,
	input logic [2:0] writeReg,
	input logic [15:0] writeData,
	output logic [15:0] readData1,
	output logic [15:0] readData2
);

	import decodePkg::*;

	logic [15:0] regs [REG_COUNT];
	logic bypass1;
	logic bypass2;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= 16'd0;
			end
		end else if (writeEnable) begin
			regs[writeReg] <= writeData;
		end
	end

	// A read of the register being written this cycle sees the new value.
	assign bypass1 = writeEnable && (writeReg == readReg1);
	assign bypass2 = writeEnable && (writeReg == readReg2);

	assign readData1 = bypass1 ? writeData : regs[readReg1];
	assign readData2 = bypass2 ? writeData : regs[readReg2];

	// The write-back stage must name a real register when it writes.
	assert property (@(posedge clk) disable iff (rst)
		writeEnable |-> !$isunknown(writeReg))
		else $error("Write-back register number is unknown.");

endmodule

// ==== source/decodeStage.sv ====
module decodeStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	input decodePkg::instrWord instr,
	input logic stall,
	input logic flush,
	input logic wbEnable,
	input logic [2:0] wbReg,
	input logic [15:0] wbData,
	output logic outValid,
	output logic [4:0] opcode,
	output decodePkg::instrFormat format,
	output logic [15:0] readData1,
	output logic [15:0] readData2,
	output logic [15:0] immed,
	output logic [2:0] writeReg,
	output logic regWrite,
	output logic memRead,
	output logic memWrite
);

	import decodePkg::*;

	instrFormat decFormat;
	logic decRegWrite;
	logic decMemRead;
	logic decMemWrite;
	logic [2:0] readReg1;
	logic [2:0] readReg2;
	logic [2:0] decWriteReg;
	logic [15:0] decImmed;
	logic [15:0] rfData1;
	logic [15:0] rfData2;

	formatClassifier classifier (
		.opcode(instr.jFmt.opcode),
		.format(decFormat),
		.regWrite(decRegWrite),
		.memRead(decMemRead),
		.memWrite(decMemWrite)
	);

	operandDecoder decoder (
		.instr(instr),
		.format(decFormat),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeReg(decWriteReg),
		.immed(decImmed)
	);

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.readReg1(readReg1),
		.readReg2(readReg2),
		.writeEnable(wbEnable), // Write-back runs even while stalled.
		.writeReg(wbReg),
		.writeData(wbData),
		.readData1(rfData1),
		.readData2(rfData2)
	);

	// Control half of the pipeline register. Flush wins over stall.
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			outValid <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else if (!stall) begin
			outValid <= inValid;
			regWrite <= inValid & decRegWrite; // A bubble must not write anything.
			memRead <= inValid & decMemRead;
			memWrite <= inValid & decMemWrite;
		end
	end

	// Payload half. It only follows the stall.
	always_ff @(posedge clk) begin
		if (!stall) begin
			opcode <= instr.jFmt.opcode;
			format <= decFormat;
			readData1 <= rfData1;
			readData2 <= rfData2;
			immed <= decImmed;
			writeReg <= decWriteReg;
		end
	end

	// Nothing leaves the stage in the first cycle out of reset.
	assert property (@(posedge clk) rst |=> !outValid)
		else $error("Output valid set right after reset.");

endmodule

// ==== test/decodeStageTb.sv ====
module decodeStageTb;

	import decodePkg::*;

	localparam int TEST_CYCLES = 340; // Reset, register sweep, three opcode sweeps and the rest.
	localparam int MARGIN_CYCLES = 60;

	logic clk;
	logic rst;
	logic inValid;
	instrWord instr;
	logic stall;
	logic flush;
	logic wbEnable;
	logic [2:0] wbReg;
	logic [15:0] wbData;
	logic outValid;
	logic [4:0] opcode;
	instrFormat format;
	logic [15:0] readData1;
	logic [15:0] readData2;
	logic [15:0] immed;
	logic [2:0] writeReg;
	logic regWrite;
	logic memRead;
	logic memWrite;

	logic [15:0] mirror [REG_COUNT]; // Expected register contents.
	logic [31:0] lfsr;

	decodeStage dut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.stall(stall),
		.flush(flush),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.outValid(outValid),
		.opcode(opcode),
		.format(format),
		.readData1(readData1),
		.readData2(readData2),
		.immed(immed),
		.writeReg(writeReg),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * 100);
		$display("Watchdog expired before the tests finished.");
		$display("Done: errors found");
		$fatal(1);
	end

	function automatic logic [15:0] randomBits(input int count);
		logic [15:0] bits;
		bits = 16'd0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			bits = {bits[14:0], lfsr[0]}; // One step per bit taken.
		end
		return bits;
	endfunction

	task automatic checkWord(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic checkReg(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic checkFormat(input instrFormat got, input instrFormat exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// Reference decode built from the format and field rules of the instruction set.
	task automatic predict(input logic [15:0] word, output instrFormat fmt, output logic rw,
			output logic mr, output logic mw, output logic [2:0] rr1, output logic [2:0] rr2,
			output logic [2:0] wr, output logic [15:0] imm);
		logic [4:0] op;
		logic [2:0] rs;
		op = word[15:11];
		rs = word[10:8];
		if (op == OP_HALT || op == OP_NOP || op == OP_J || op == OP_JAL) begin
			fmt = FMT_J;
		end else if (op == OP_JR || op == OP_JALR || op == OP_LBI || op == OP_SLBI
				|| op[4:2] == 3'b011) begin
			fmt = FMT_I2;
		end else if (op == OP_BTR || op[4:1] == 4'b1101 || op[4:2] == 3'b111) begin
			fmt = FMT_R;
		end else begin
			fmt = FMT_I1;
		end
		rw = (fmt == FMT_R) || (fmt == FMT_I1 && op != OP_ST) || op == OP_JAL
			|| op == OP_JALR || op == OP_LBI || op == OP_SLBI;
		mr = (op == OP_LD);
		mw = (op == OP_ST) || (op == OP_STU);
		rr1 = (fmt == FMT_J) ? 3'd0 : rs;
		rr2 = 3'd0;
		wr = 3'd0;
		imm = 16'd0;
		if (fmt == FMT_J) begin
			wr = (op == OP_JAL) ? LINK_REG : 3'd0;
			imm = {{5{word[10]}}, word[10:0]};
		end else if (fmt == FMT_I1) begin
			rr2 = mw ? word[7:5] : 3'd0; // Both stores read their data from rd.
			wr = (op == OP_STU) ? rs : word[7:5];
			imm = (word[14] && word[12]) ? {11'd0, word[4:0]} : {{11{word[4]}}, word[4:0]};
		end else if (fmt == FMT_I2) begin
			if (op == OP_JALR) begin
				wr = LINK_REG;
			end else if (op == OP_LBI || op == OP_SLBI) begin
				wr = rs;
			end
			imm = (word[15] && word[12] != word[11]) ? {8'd0, word[7:0]}
				: {{8{word[7]}}, word[7:0]};
		end else begin
			rr2 = word[7:5];
			wr = word[4:2];
		end
	endtask

	task automatic verifyOutputs(input logic [15:0] word, input logic en, input logic [2:0] r,
			input logic [15:0] d);
		instrFormat fmt;
		logic rw;
		logic mr;
		logic mw;
		logic [2:0] rr1;
		logic [2:0] rr2;
		logic [2:0] wr;
		logic [15:0] imm;
		predict(word, fmt, rw, mr, mw, rr1, rr2, wr, imm);
		checkFlag(outValid, 1'b1, "outValid");
		checkReg(opcode[2:0], word[13:11], "opcode low bits");
		checkReg({1'b0, opcode[4:3]}, {1'b0, word[15:14]}, "opcode high bits");
		checkFormat(format, fmt, "format");
		checkFlag(regWrite, rw, "regWrite");
		checkFlag(memRead, mr, "memRead");
		checkFlag(memWrite, mw, "memWrite");
		checkReg(writeReg, wr, "writeReg");
		checkWord(immed, imm, "immed");
		checkWord(readData1, (en && r == rr1) ? d : mirror[rr1], "readData1");
		checkWord(readData2, (en && r == rr2) ? d : mirror[rr2], "readData2");
	endtask

	// Presents one instruction with an optional write-back and checks it a cycle later.
	task automatic decodeOne(input logic [15:0] word, input logic en, input logic [2:0] r,
			input logic [15:0] d);
		@(posedge clk);
		instr <= word;
		inValid <= 1'b1;
		wbEnable <= en;
		wbReg <= r;
		wbData <= d;
		@(posedge clk);
		inValid <= 1'b0;
		wbEnable <= 1'b0;
		@(negedge clk);
		verifyOutputs(word, en, r, d);
		if (en) begin
			mirror[r] = d;
		end
	endtask

	task automatic resetCheck();
		@(negedge clk);
		checkFlag(outValid, 1'b0, "outValid after reset");
		checkFlag(regWrite, 1'b0, "regWrite after reset");
		checkFlag(memRead, 1'b0, "memRead after reset");
		checkFlag(memWrite, 1'b0, "memWrite after reset");
		for (int i = 0; i < REG_COUNT; i++) begin
			decodeOne({OP_BTR, 3'(i), 3'(i), 3'd0, 2'd0}, 1'b0, 3'd0, 16'd0);
		end
	endtask

	task automatic opcodeSweep();
		logic [15:0] fields;
		repeat (2) begin
			for (int i = 0; i < 32; i++) begin
				fields = randomBits(11);
				decodeOne({5'(i), fields[10:0]}, 1'b0, 3'd0, 16'd0);
			end
		end
		for (int i = 0; i < 32; i++) begin
			decodeOne({5'(i), 11'h7ff}, 1'b0, 3'd0, 16'd0); // Every immediate has its top bit set.
		end
	endtask

	task automatic registerReads();
		for (int i = 0; i < REG_COUNT; i++) begin
			decodeOne({OP_NOP, 11'd0}, 1'b1, 3'(i), randomBits(16));
		end
		for (int i = 0; i < REG_COUNT; i++) begin
			decodeOne({OP_BTR, 3'(i), 3'(7 - i), 3'd0, 2'd0}, 1'b0, 3'd0, 16'd0);
			decodeOne({OP_ST, 3'(i), 3'(i + 3), 5'd1}, 1'b0, 3'd0, 16'd0);
		end
	endtask

	task automatic bypassRead();
		decodeOne({OP_BTR, 3'd5, 3'd2, 3'd0, 2'd0}, 1'b1, 3'd5, randomBits(16));
		decodeOne({OP_STU, 3'd1, 3'd5, 5'h1f}, 1'b1, 3'd5, randomBits(16)); // Second read port.
	endtask

	task automatic stallFlush();
		logic [15:0] held;
		held = {OP_STU, 3'd2, 3'd6, 5'h0b};
		@(posedge clk);
		instr <= held;
		inValid <= 1'b1;
		@(posedge clk);
		instr <= {OP_LD, 3'd4, 3'd1, 5'h10}; // This one is dropped.
		stall <= 1'b1;
		@(negedge clk);
		verifyOutputs(held, 1'b0, 3'd0, 16'd0);
		@(posedge clk);
		flush <= 1'b1;
		@(negedge clk);
		verifyOutputs(held, 1'b0, 3'd0, 16'd0);
		@(posedge clk);
		flush <= 1'b0;
		stall <= 1'b0;
		inValid <= 1'b0;
		@(negedge clk);
		checkFlag(outValid, 1'b0, "outValid after flush");
		checkFlag(regWrite, 1'b0, "regWrite after flush");
		checkFlag(memRead, 1'b0, "memRead after flush");
		checkFlag(memWrite, 1'b0, "memWrite after flush");
	endtask

	initial begin
		lfsr = 32'h4ac4_3899;
		rst = 1'b1;
		inValid = 1'b0;
		instr = 16'd0;
		stall = 1'b0;
		flush = 1'b0;
		wbEnable = 1'b0;
		wbReg = 3'd0;
		wbData = 16'd0;
		for (int i = 0; i < REG_COUNT; i++) begin
			mirror[i] = 16'd0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		resetCheck();
		opcodeSweep();
		registerReads();
		bypassRead();
		stallFlush();
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== build.f ====
source/decodePkg.sv
source/formatClassifier.sv
source/operandDecoder.sv
source/registerFile.sv
source/decodeStage.sv
test/decodeStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module decodeStageTb \
	-Mdir obj_dir -o simDecode
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status."
	exit 1
fi

./obj_dir/simDecode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "Done: no errors" sim.log; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed."
	exit 1
fi
